// File: fifo_input.txt
# W data | R expected rdata | F full almost_full | E empty | S idle clk cycles
# Values in hex; F and E wait six cycles of their clock before sampling
F 0 0
E 1
# Reads and writes interleaved across the two clocks
W 10
W 11
R 10
W 12
R 11
W 13
R 12
R 13
E 1
# Fill up, almost_full at six words, full at eight
W 20
W 21
W 22
W 23
W 24
W 25
F 0 1
W 26
W 27
F 1 1
W 28
F 1 1
# Ninth word above was dropped
R 20
R 21
R 22
R 23
R 24
R 25
R 26
R 27
E 1
F 0 0
# Read while empty keeps the last word
R 27
W 30
S 3
R 30
E 1
# Second fill and drain, pointers wrap
W 40
W 41
W 42
W 43
W 44
W 45
F 0 1
W 46
W 47
F 1 1
R 40
R 41
R 42
R 43
R 44
R 45
R 46
R 47
E 1
F 0 0

// File: flist.f
fifo_cfg_pkg.sv
fifo_port_pkg.sv
gray_sync.sv
fifo_mem.sv
fifo_wr_ptr.sv
fifo_rd_ptr.sv
async_fifo.sv
tb_async_fifo.sv

// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_async_fifo -f flist.f

run: compile
	./obj_dir/Vtb_async_fifo > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG) || ! grep -q "No errors" $(LOG); then \
		echo "Simulation failed"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

// File: tb_async_fifo.sv
module tb_async_fifo import fifo_cfg_pkg::*, fifo_port_pkg::*; ();

    logic     clk;
    logic     rd_clk;
    logic     reset_n;
    logic     rd_reset_n;
    wr_req_t  wr_req;
    rd_req_t  rd_req;
    wr_stat_t wr_stat;
    rd_resp_t rd_resp;

    byte    cmd_q[$];           // Command letters from the data file
    int     arg_a_q[$];         // First value of each command
    int     arg_b_q[$];         // Second value, F only
    int     n_lines;            // Lines read, comments included
    int     cycle_limit = 0;    // Zero until the file is loaded
    int     cycles = 0;
    int     errors = 0;
    int     checks = 0;
    int     stored = 0;         // Words the FIFO should hold by the write and read rules
    integer seed;

    async_fifo uut (
        .clk        (clk),
        .reset_n    (reset_n),
        .wr_req     (wr_req),
        .wr_stat    (wr_stat),
        .rd_clk     (rd_clk),
        .rd_reset_n (rd_reset_n),
        .rd_req     (rd_req),
        .rd_resp    (rd_resp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;        // Write clock, period 100
    end

    initial begin
        rd_clk = 1'b0;
        forever #65 rd_clk = ~rd_clk;  // Read clock, period 130, unrelated to clk
    end

    // Watchdog on the write clock
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: run stopped after %0d clk cycles without finishing", cycles);
            $display("Errors found");
            $finish;
        end
    end

    task automatic check(input string what, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    // Drive points sit 5 units after each rising edge
    task automatic next_wr_slot();
        @(posedge clk);
        #5;
    endtask

    task automatic next_rd_slot();
        @(posedge rd_clk);
        #5;
    endtask

    task automatic write_word(input data_t value);
        next_wr_slot();
        if (stored < fifo_depth) begin
            while (wr_stat.full) begin
                next_wr_slot();            // Full may lag a read by a few edges
            end
            stored++;
        end                                // Otherwise the write must be dropped
        wr_req.write = 1'b1;
        wr_req.wdata = value;
        next_wr_slot();                    // Accepted at this edge
        wr_req.write = 1'b0;
    endtask

    task automatic read_word(input data_t expected);
        next_rd_slot();
        if (stored > 0) begin
            while (rd_resp.empty) begin
                next_rd_slot();            // Write pointer still crossing over
            end
            stored--;
        end                                // Empty read, rdata has to hold
        rd_req.read = 1'b1;
        next_rd_slot();
        rd_req.read = 1'b0;
        check("rdata", 32'(rd_resp.rdata), 32'(expected));
    endtask

    // Six edges let the synchronizers settle before sampling
    task automatic check_wr_flags(input int full_exp, input int af_exp);
        repeat (6) next_wr_slot();
        check("full", 32'(wr_stat.full), full_exp);
        check("almost_full", 32'(wr_stat.almost_full), af_exp);
    endtask

    task automatic check_empty(input int empty_exp);
        repeat (6) next_rd_slot();
        check("empty", 32'(rd_resp.empty), empty_exp);
    endtask

    task automatic idle_gap();
        int gap;
        gap = $unsigned($random(seed)) % 3;   // 0 to 2 idle clk cycles
        repeat (gap) next_wr_slot();
    endtask

    task automatic load_commands(output bit loaded);
        int    fd;
        int    code;
        int    a;
        int    b;
        byte   c;
        string rest;
        loaded  = 1'b0;
        n_lines = 0;
        fd = $fopen("fifo_input.txt", "r");
        if (fd != 0) begin
            loaded = 1'b1;
            code = $fscanf(fd, " %c", c);
            while (code == 1) begin
                n_lines++;
                a = 0;
                b = 0;
                if (c == "F") begin
                    code = $fscanf(fd, "%h %h", a, b);
                end else if (c == "W" || c == "R" || c == "E" || c == "S") begin
                    code = $fscanf(fd, "%h", a);
                end else begin
                    code = $fgets(rest, fd);     // Comment or junk, skip the line
                end
                if (c == "W" || c == "R" || c == "E" || c == "S" || c == "F") begin
                    cmd_q.push_back(c);
                    arg_a_q.push_back(a);
                    arg_b_q.push_back(b);
                end else if (c != "#") begin
                    errors++;
                    $display("Unknown command '%c' in fifo_input.txt, line skipped", c);
                end
                code = $fscanf(fd, " %c", c);
            end
            $fclose(fd);
        end
    endtask

    initial begin
        bit loaded;
        seed       = 53;
        reset_n    = 1'b0;
        rd_reset_n = 1'b0;
        wr_req     = '0;
        rd_req     = '0;
        load_commands(loaded);
        if (!loaded) begin
            $display("Stimulus file fifo_input.txt could not be opened");
            $display("Errors found");
        end else begin
            cycle_limit = 10 * n_lines + 200;
            fork
                begin
                    repeat (10) @(posedge clk);
                    #5 reset_n = 1'b1;
                end
                begin
                    repeat (10) @(posedge rd_clk);
                    #5 rd_reset_n = 1'b1;
                end
            join
            for (int i = 0; i < cmd_q.size(); i++) begin
                case (cmd_q[i])
                    "W": begin
                        write_word(data_t'(arg_a_q[i]));
                        idle_gap();
                    end
                    "R": begin
                        read_word(data_t'(arg_a_q[i]));
                        idle_gap();
                    end
                    "F": check_wr_flags(arg_a_q[i], arg_b_q[i]);
                    "E": check_empty(arg_a_q[i]);
                    default: repeat (arg_a_q[i]) next_wr_slot();   // S, plain idle
                endcase
            end
            $display("Checks run: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
        end
        $finish;
    end

endmodule

// File: async_fifo.sv
module async_fifo import fifo_cfg_pkg::*, fifo_port_pkg::*; (
    // Write domain
    input  logic     clk,
    input  logic     reset_n,
    input  wr_req_t  wr_req,
    output wr_stat_t wr_stat,

    // Read domain
    input  logic     rd_clk,
    input  logic     rd_reset_n,
    input  rd_req_t  rd_req,
    output rd_resp_t rd_resp
);

    addr_t w_addr;        // Memory write address
    addr_t r_addr;        // Memory read address
    ptr_t  w_ptr;         // Gray write pointer, clk domain
    ptr_t  r_ptr;         // Gray read pointer, rd_clk domain
    ptr_t  wr_ptr_sync;   // Write pointer seen on rd_clk
    ptr_t  rd_ptr_sync;   // Read pointer seen on clk
    logic  wr_en;
    logic  read_en;
    logic  empty;
    data_t rdata;

    // Same gating as inside fifo_wr_ptr, so memory and pointer agree
    assign wr_en = wr_req.write & ~wr_stat.full;

    fifo_wr_ptr u_wr_ptr (
        .clk     (clk),
        .reset_n (reset_n),
        .write   (wr_req.write),
        .rd_ptr  (rd_ptr_sync),
        .stat    (wr_stat),
        .w_addr  (w_addr),
        .w_ptr   (w_ptr)
    );

    fifo_rd_ptr u_rd_ptr (
        .rd_clk     (rd_clk),
        .rd_reset_n (rd_reset_n),
        .read       (rd_req.read),
        .wr_ptr     (wr_ptr_sync),
        .empty      (empty),
        .r_addr     (r_addr),
        .r_ptr      (r_ptr),
        .read_en    (read_en)
    );

    // Write pointer into the read domain
    gray_sync u_wr2rd_sync (
        .clk     (rd_clk),
        .reset_n (rd_reset_n),
        .ptr_in  (w_ptr),
        .ptr_out (wr_ptr_sync)
    );

    // Read pointer into the write domain
    gray_sync u_rd2wr_sync (
        .clk     (clk),
        .reset_n (reset_n),
        .ptr_in  (r_ptr),
        .ptr_out (rd_ptr_sync)
    );

    fifo_mem u_mem (
        .clk    (clk),
        .wr_en  (wr_en),
        .w_addr (w_addr),
        .wdata  (wr_req.wdata),
        .rd_clk (rd_clk),
        .rd_en  (read_en),
        .r_addr (r_addr),
        .rdata  (rdata)
    );

    assign rd_resp.empty = empty;
    assign rd_resp.rdata = rdata;   // Held in the memory's output register

    // Full can only follow a write and is never raised by a read
    a_full_needs_write: assert property (
        @(posedge clk) disable iff (!reset_n)
        $rose(wr_stat.full) |-> $past(wr_en)
    ) else $error("full raised without a write");

    // Empty can only follow a read; writes never make the FIFO look emptier
    a_empty_needs_read: assert property (
        @(posedge rd_clk) disable iff (!rd_reset_n)
        $rose(empty) |-> $past(read_en)
    ) else $error("empty raised without a read");

endmodule

// File: fifo_rd_ptr.sv
module fifo_rd_ptr import fifo_cfg_pkg::*; (
    input  logic  rd_clk,
    input  logic  rd_reset_n,

    input  logic  read,      // Read strobe from the consumer
    input  ptr_t  wr_ptr,    // Write pointer in Gray code, synchronized to rd_clk
    output logic  empty,     // Registered empty flag
    output addr_t r_addr,    // Binary address into the memory
    output ptr_t  r_ptr,     // Registered Gray read pointer for the write domain
    output logic  read_en    // Accepted read, loads rdata in the memory
);

    ptr_t rd_ptr_bin;          // Current binary read pointer
    ptr_t rd_ptr_bin_next;
    ptr_t rd_ptr_gray_next;
    logic empty_next;

    assign read_en          = read & ~empty;   // Reads on an empty FIFO do nothing
    assign rd_ptr_bin_next  = rd_ptr_bin + ptr_t'(read_en);
    assign rd_ptr_gray_next = bin2gray(rd_ptr_bin_next);

    // Both pointers equal in Gray, wrap bit included, means nothing stored
    assign empty_next = (rd_ptr_gray_next == wr_ptr);

    always_ff @(posedge rd_clk) begin
        if (!rd_reset_n) begin
            rd_ptr_bin <= '0;
            r_ptr      <= '0;
            empty      <= 1'b1;                 // Starts empty
        end else begin
            rd_ptr_bin <= rd_ptr_bin_next;
            r_ptr      <= rd_ptr_gray_next;
            empty      <= empty_next;
        end
    end

    // Current pointer already points at the oldest word
    assign r_addr = rd_ptr_bin[addr_width-1:0];

    // Nothing left to read freezes the pointer until the write domain catches up
    a_no_advance_when_empty: assert property (
        @(posedge rd_clk) disable iff (!rd_reset_n)
        ptr_dist(rd_ptr_bin, gray2bin(wr_ptr)) == '0 |=> $stable(rd_ptr_bin)
    ) else $error("read pointer advanced while empty");

    // Read pointer never overtakes the synchronized write pointer
    a_rd_behind_wr: assert property (
        @(posedge rd_clk) disable iff (!rd_reset_n)
        ptr_dist(rd_ptr_bin, gray2bin(wr_ptr)) <= ptr_t'(fifo_depth)
    ) else $error("read pointer ran past write pointer");

endmodule

// File: fifo_wr_ptr.sv
module fifo_wr_ptr import fifo_cfg_pkg::*, fifo_port_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,

    input  logic     write,     // Write strobe from the producer
    input  ptr_t     rd_ptr,    // Read pointer in Gray code, already synchronized to clk
    output wr_stat_t stat,      // Registered full and almost_full
    output addr_t    w_addr,    // Binary address into the memory
    output ptr_t     w_ptr      // Registered Gray write pointer for the read domain
);

    ptr_t     wr_ptr_bin;        // Current binary write pointer
    ptr_t     wr_ptr_bin_next;   // Pointer after this cycle's write, if any
    ptr_t     wr_ptr_gray_next;  // Gray of the next pointer
    ptr_t     rd_ptr_bin;        // Read pointer back in binary
    ptr_t     wr_ptr_af;         // Next pointer plus the almost-full headroom
    logic     wr_accept;         // Write strobe gated by full
    wr_stat_t stat_next;

    // Writes while full are dropped and the pointer stays put
    assign wr_accept       = write & ~stat.full;
    assign wr_ptr_bin_next = wr_ptr_bin + ptr_t'(wr_accept);
    assign wr_ptr_gray_next = bin2gray(wr_ptr_bin_next);

    assign rd_ptr_bin = gray2bin(rd_ptr);
    assign wr_ptr_af  = wr_ptr_bin_next + ptr_t'(almost_full_diff);

    always_comb begin
        // Full when the write pointer is one lap ahead of the read pointer
        // In Gray code that means the top two bits inverted, the rest equal
        stat_next.full = (wr_ptr_gray_next ==
                          {~rd_ptr[addr_width:addr_width-1], rd_ptr[addr_width-2:0]});

        // Headroom pushes the pointer a full lap past the read pointer once six words are held
        stat_next.almost_full = (ptr_dist(rd_ptr_bin, wr_ptr_af) >= ptr_t'(fifo_depth));
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_ptr_bin <= '0;
            w_ptr      <= '0;
            stat       <= '0;                   // Not full, not almost full
        end else begin
            wr_ptr_bin <= wr_ptr_bin_next;
            w_ptr      <= wr_ptr_gray_next;     // Registered so only one bit moves per edge
            stat       <= stat_next;            // Flags track the pointer just written
        end
    end

    assign w_addr = wr_ptr_bin[addr_width-1:0];   // Wrap bit dropped for the memory

    // Once a full lap is stored the pointer holds until a read frees space
    a_no_advance_when_full: assert property (
        @(posedge clk) disable iff (!reset_n)
        ptr_dist(rd_ptr_bin, wr_ptr_bin) == ptr_t'(fifo_depth) |=> $stable(wr_ptr_bin)
    ) else $error("write pointer advanced while full");

    // Stale read pointer only makes the FIFO look fuller, never emptier
    a_fill_in_range: assert property (
        @(posedge clk) disable iff (!reset_n)
        ptr_dist(rd_ptr_bin, wr_ptr_bin) <= ptr_t'(fifo_depth)
    ) else $error("write pointer more than one lap ahead of read pointer");

endmodule

// File: fifo_mem.sv
module fifo_mem import fifo_cfg_pkg::*; (
    // Write port, producer clock
    input  logic  clk,
    input  logic  wr_en,     // Accepted write
    input  addr_t w_addr,
    input  data_t wdata,

    // Read port, consumer clock
    input  logic  rd_clk,
    input  logic  rd_en,     // Accepted read
    input  addr_t r_addr,
    output data_t rdata      // Holds until the next accepted read
);

    data_t mem [fifo_depth];   // Storage, no reset needed

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[w_addr] <= wdata;
        end
    end

    // Registered read; word appears at the edge that accepts the read
    always_ff @(posedge rd_clk) begin
        if (rd_en) begin
            rdata <= mem[r_addr];
        end
    end

    // Pointers keep read and write on different entries, so the two
    // ports never touch the same word in the same cycle

endmodule

// File: gray_sync.sv
module gray_sync import fifo_cfg_pkg::*; (
    input  logic clk,        // Destination clock
    input  logic reset_n,    // Destination reset
    input  ptr_t ptr_in,     // Gray pointer from the other domain
    output ptr_t ptr_out     // Same pointer, two edges later
);

    ptr_t meta_q;   // First stage, may go metastable

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            meta_q  <= '0;
            ptr_out <= '0;
        end else begin
            meta_q  <= ptr_in;
            ptr_out <= meta_q;    // Second stage gives the first one a cycle to settle
        end
    end

    // A Gray counter only steps forward
    // The source may be the faster clock, so several steps can land in one
    // sample, but never more than a full lap and never a step back
    a_ptr_forward: assert property (
        @(posedge clk) disable iff (!reset_n)
        ptr_dist(gray2bin($past(ptr_out)), gray2bin(ptr_out)) <= ptr_t'(fifo_depth)
    ) else $error("synchronized pointer moved backwards");

endmodule

// File: fifo_port_pkg.sv
package fifo_port_pkg;

    import fifo_cfg_pkg::*;

    // Write domain, driven by the producer on clk
    typedef struct packed {
        logic  write;   // Write strobe, ignored while full
        data_t wdata;   // Word stored on an accepted write
    } wr_req_t;

    // Write domain status, registered in fifo_wr_ptr
    typedef struct packed {
        logic full;          // No free entry left
        logic almost_full;   // Six or more words stored
    } wr_stat_t;

    // Read domain, driven by the consumer on rd_clk
    typedef struct packed {
        logic read;   // Read strobe, ignored while empty
    } rd_req_t;

    // Read domain response
    typedef struct packed {
        logic  empty;   // Nothing to read
        data_t rdata;   // Word from the last accepted read
    } rd_resp_t;

    // Write side and read side travel separately since they live in
    // different clock domains

endpackage

// File: fifo_cfg_pkg.sv
package fifo_cfg_pkg;

    // FIFO geometry
    localparam int addr_width       = 3;                 // Memory address bits
    localparam int fifo_depth       = 1 << addr_width;   // Eight entries
    localparam int data_width       = 8;                 // Word size
    localparam int almost_full_diff = 2;                 // Headroom kept past the next write

    typedef logic [data_width-1:0] data_t;   // One data word
    typedef logic [addr_width-1:0] addr_t;   // Memory address
    typedef logic [addr_width:0]   ptr_t;    // Address plus wrap bit, binary or Gray

    // Binary count to reflected Gray code
    function automatic ptr_t bin2gray(input ptr_t bin);
        return (bin >> 1) ^ bin;
    endfunction

    // Gray code back to binary
    // MSB passes straight through, every lower bit folds in the bits above it
    function automatic ptr_t gray2bin(input ptr_t gray);
        ptr_t bin;
        bin[addr_width] = gray[addr_width];
        for (int i = addr_width - 1; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    // Distance from one binary pointer to another, modulo the pointer range
    // Wrap bit included so a full FIFO reads as fifo_depth and not as zero
    function automatic ptr_t ptr_dist(input ptr_t from_ptr, input ptr_t to_ptr);
        return to_ptr - from_ptr;
    endfunction

endpackage
